//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --timing --assert
TOP ?= f8_core_tb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/f8_core_assert.sv
// f8 core port checks
// write enables, reset quiet, halt behavior and fetch order
`default_nettype none

module f8_core_assert (
	input logic clk,
	input logic reset,
	input f8_core_pkg::word_t mem_read_addr,
	input f8_core_pkg::byte_t mem_read_data,
	input logic [1:0] mem_write_en,
	input logic trap
);

	int fail_count = 0;
	logic reset_q = 1'b0;

	always @(posedge clk)
		reset_q <= reset;

	// high byte alone is never written
	assert property (@(posedge clk) disable iff (reset) mem_write_en != 2'b10)
	else
	begin
		fail_count++;
		$error("high byte written without the low byte");
	end

	assert property (@(posedge clk) (reset && reset_q) |-> mem_write_en == 2'b00)
	else
	begin
		fail_count++;
		$error("memory write while in reset");
	end

	assert property (@(posedge clk) disable iff (reset) trap |=> trap && $stable(mem_read_addr))
	else
	begin
		fail_count++;
		$error("core left the halt state without reset");
	end

	assert property (@(posedge clk) disable iff (reset) trap |-> mem_write_en == 2'b00)
	else
	begin
		fail_count++;
		$error("memory write after trap");
	end

	// a taken jump lands at its own address plus the offset byte now on the bus
	assert property (@(posedge clk) disable iff (reset)
		(!reset_q && !trap) |-> (mem_read_addr == $past(mem_read_addr) + 16'd1
		|| mem_read_addr == $past(mem_read_addr) - 16'd1
		+ {{8{mem_read_data[7]}}, mem_read_data}))
	else
	begin
		fail_count++;
		$error("read address moved by something other than a step or a jump");
	end

endmodule

`default_nettype wire

//--- dv/f8_core_tb.sv
// f8 core testbench
// random programs against a reference model, with a byte memory model
`default_nettype none

module f8_core_tb;

	localparam int NTESTS = 8;
	localparam int MAXLEN = 128;

	logic clk;
	logic reset;
	logic reset_q;
	f8_core_pkg::word_t mem_read_addr;
	f8_core_pkg::byte_t mem_read_data;
	f8_core_pkg::word_t mem_write_addr;
	f8_core_pkg::word_t mem_write_data;
	logic [1:0] mem_write_en;
	logic trap;

	f8_core_pkg::byte_t mem [65536];
	f8_core_pkg::byte_t code [NTESTS][MAXLEN];
	int code_len [NTESTS];
	int store_cnt [NTESTS];
	// en, address, data
	logic [33:0] exp_q [$];
	f8_core_pkg::word_t m_x, m_y, st_ptr;
	logic f_c, f_z, gen_done;
	int gen_t, errors, total_bytes;
	longint budget;

	f8_core f8_core_i (.*);

	bind f8_core f8_core_assert f8_core_assert_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// memory answers one cycle late
	always @(posedge clk)
	begin
		mem_read_data <= mem[mem_read_addr];
		if (mem_write_en[0])
			mem[mem_write_addr] <= mem_write_data[7:0];
		if (mem_write_en[1])
			mem[mem_write_addr + 16'd1] <= mem_write_data[15:8];
	end

	always @(posedge clk)
	begin
		logic [33:0] exp;
		reset_q <= reset;
		if (reset && reset_q)
			assert (mem_read_addr == f8_core_pkg::RESET_PC && mem_write_en == 2'b00 && !trap)
			else
			begin
				$display("mismatch at %0t: reset state addr %h en %b trap %b", $time,
					mem_read_addr, mem_write_en, trap);
				errors++;
			end
		if (!reset && mem_write_en != 2'b00)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected store to %h at %0t", mem_write_addr, $time);
				errors++;
			end
			else
			begin
				exp = exp_q.pop_front();
				assert ({mem_write_en, mem_write_addr, mem_write_data} == exp)
				else
				begin
					$display("mismatch at %0t: store en %b addr %h data %h, expected %h",
						$time, mem_write_en, mem_write_addr, mem_write_data, exp);
					errors++;
				end
			end
		end
	end

	task automatic put(input f8_core_pkg::byte_t b);
		code[gen_t][code_len[gen_t]] = b;
		code_len[gen_t]++;
	endtask

	task automatic put_word(input f8_core_pkg::word_t w);
		put(w[7:0]);
		put(w[15:8]);
	endtask

	task automatic emit_store(input logic word, input logic kept);
		put(word ? 8'h31 : 8'h30);
		put_word(st_ptr);
		if (kept)
		begin
			if (word)
				exp_q.push_back({2'b11, st_ptr, m_y});
			else
				exp_q.push_back({2'b01, st_ptr, 8'h00, m_x[7:0]});
			store_cnt[gen_t]++;
		end
		st_ptr += 16'd2;
	endtask

	// sub is a + ~b + 1, sbc is a + ~b + C
	task automatic alu_ref(input int w, input logic [2:0] op, input f8_core_pkg::word_t a,
		input f8_core_pkg::word_t imm, output f8_core_pkg::word_t r);
		f8_core_pkg::word_t mask, bb;
		logic cin;
		logic [16:0] full;
		mask = (w == 8) ? 16'h00ff : 16'hffff;
		bb = (op == 3'd2 || op == 3'd3) ? (~imm) & mask : imm & mask;
		cin = (op == 3'd2) || ((op == 3'd1 || op == 3'd3) && f_c);
		full = {1'b0, a & mask} + {1'b0, bb} + 17'(cin);
		case (op)
			3'd4: r = (a | imm) & mask;
			3'd5: r = (a & imm) & mask;
			3'd6: r = (a ^ imm) & mask;
			3'd7: r = imm & mask;
			default: r = full[15:0] & mask;
		endcase
		if (op < 3'd4)
			f_c = (w == 8) ? full[8] : full[16];
		if (!(w == 8 && op == 3'd7))
			f_z = (r == 16'h0000);
	endtask

	task automatic gen_program(input int t);
		f8_core_pkg::byte_t imm8;
		f8_core_pkg::word_t imm16, r;
		logic [2:0] op;
		int blocks;
		logic taken;
		gen_t = t;
		code_len[t] = 0;
		store_cnt[t] = 0;
		f_c = 1'b0;
		f_z = 1'b0;
		imm8 = 8'($urandom);
		put(8'h17);
		put(imm8);
		m_x[7:0] = imm8;
		imm16 = 16'($urandom);
		put(8'h27);
		put_word(imm16);
		alu_ref(16, 3'd7, m_y, imm16, m_y);
		blocks = 6 + int'($urandom % 15);
		for (int i = 0; i < blocks; i++)
		begin
			op = 3'($urandom % 8);
			case ($urandom % 3)
				0:
				begin
					imm8 = 8'($urandom);
					put({5'b00010, op});
					put(imm8);
					alu_ref(8, op, {8'h00, m_x[7:0]}, {8'h00, imm8}, r);
					m_x[7:0] = r[7:0];
					emit_store(1'b0, 1'b1);
				end
				1:
				begin
					// there is no andw opcode
					if (op == 3'd5)
						op = 3'd7;
					imm16 = 16'($urandom);
					put({5'b00100, op});
					put_word(imm16);
					alu_ref(16, op, m_y, imm16, r);
					m_y = r;
					emit_store(1'b1, 1'b1);
				end
				default:
				begin
					op = 3'($urandom % 5);
					case (op)
						3'd1: taken = f_z;
						3'd2: taken = !f_z;
						3'd3: taken = f_c;
						3'd4: taken = !f_c;
						default: taken = 1'b1;
					endcase
					// jump over the guarded store
					put(8'h40 + {5'b0, op});
					put(8'd5);
					emit_store(1'($urandom % 2), !taken);
				end
			endcase
		end
		put(8'h01);
		total_bytes += code_len[t];
	endtask

	initial
	begin
		int stores_left;
		int err_before;
		int dummy;
		reset = 1'b1;
		mem_read_data = 8'h00;
		reset_q = 1'b0;
		errors = 0;
		total_bytes = 0;
		gen_done = 1'b0;
		st_ptr = 16'h8000;
		m_x = 16'h0000;
		m_y = 16'h0000;
		dummy = $urandom(9);
		for (int a = 0; a < 65536; a++)
			mem[a] = 8'(a ^ (a >> 8));
		for (int t = 0; t < NTESTS; t++)
			gen_program(t);
		budget = 2 * longint'(total_bytes + NTESTS * 16) * 8;
		gen_done = 1'b1;
		stores_left = exp_q.size();
		for (int t = 0; t < NTESTS; t++)
		begin
			err_before = errors;
			for (int i = 0; i < code_len[t]; i++)
				mem[int'(f8_core_pkg::RESET_PC) + i] = code[t][i];
			@(posedge clk);
			reset <= 1'b1;
			repeat (5) @(posedge clk);
			reset <= 1'b0;
			@(posedge clk);
			while (!trap)
				@(posedge clk);
			// watch the halted core for a few cycles
			repeat (6) @(posedge clk);
			stores_left -= store_cnt[t];
			assert (exp_q.size() == stores_left)
			else
			begin
				$display("test %0d: predicted stores never happened", t);
				errors++;
			end
			$display("test %0d: %0d bytes, %0d stores, %s", t, code_len[t], store_cnt[t],
				(errors == err_before) ? "ok" : "failed");
		end
		errors += f8_core_i.f8_core_assert_i.fail_count;
		$display("%0d tests run, %0d errors", NTESTS, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		wait (gen_done);
		#(budget);
		$display("timeout: the core did not reach trap in time");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
hw/f8_isa_pkg.sv
hw/f8_core_pkg.sv
hw/f8_exec_if.sv
hw/f8_regfile.sv
hw/f8_sequencer.sv
hw/f8_alu.sv
hw/f8_writeback.sv
hw/f8_core.sv
dv/f8_core_assert.sv
dv/f8_core_tb.sv

//--- hw/f8_alu.sv
// f8 ALU for one operand width
// add with carry, logic operations and flag generation
`default_nettype none

module f8_alu #(
	parameter type data_t = f8_core_pkg::byte_t
) (
	f8_exec_if.unit exec
);

	localparam int W = $bits(data_t);

	logic [W:0] sum;
	logic [4:0] half;
	data_t result;
	logic arith;

	always_comb
	begin
		sum = {1'b0, exec.a} + {1'b0, exec.b} + {{W{1'b0}}, exec.carry_in};
		half = {1'b0, exec.a[3:0]} + {1'b0, exec.b[3:0]} + {4'b0000, exec.carry_in};
		arith = 1'b0;
		unique case (exec.op)
			f8_isa_pkg::ALU_ADD, f8_isa_pkg::ALU_ADC,
			f8_isa_pkg::ALU_SUB, f8_isa_pkg::ALU_SBC:
			begin
				result = sum[W-1:0];
				arith = 1'b1;
			end
			f8_isa_pkg::ALU_OR: result = exec.a | exec.b;
			f8_isa_pkg::ALU_AND: result = exec.a & exec.b;
			f8_isa_pkg::ALU_XOR: result = exec.a ^ exec.b;
			default: result = exec.b;
		endcase
	end

	assign exec.result = result;

	// logic ops report parity in place of overflow
	always_comb
	begin
		exec.flags.c = arith && sum[W];
		exec.flags.h = arith && half[4];
		if (arith)
			exec.flags.o = (exec.a[W-1] == exec.b[W-1]) && (sum[W-1] != exec.a[W-1]);
		else
			exec.flags.o = ^result;
		exec.flags.z = ~|result;
		exec.flags.n = result[W-1];
	end

endmodule

`default_nettype wire

//--- hw/f8_core.sv
// f8 core top level
// sequencer, register file, 8 and 16 bit ALUs and writeback
`default_nettype none

module f8_core #(
	parameter f8_core_pkg::word_t RESET_PC = f8_core_pkg::RESET_PC
) (
	input logic clk,
	input logic reset,
	output f8_core_pkg::word_t mem_read_addr,
	input f8_core_pkg::byte_t mem_read_data,
	output f8_core_pkg::word_t mem_write_addr,
	output f8_core_pkg::word_t mem_write_data,
	output logic [1:0] mem_write_en,
	output logic trap
);

	f8_core_pkg::word_t x, y;
	f8_core_pkg::byte_t flags, flags_next;
	f8_core_pkg::reg_idx_t write_idx;
	f8_core_pkg::word_t write_data;
	logic [1:0] write_en;
	f8_core_pkg::word_t store_addr;
	logic store_byte, store_word;

	f8_exec_if #(.data_t(f8_core_pkg::byte_t)) exec8 ();
	f8_exec_if #(.data_t(f8_core_pkg::word_t)) exec16 ();

	f8_sequencer #(.RESET_PC(RESET_PC)) f8_sequencer_i (.*);

	// z is not an operand of any instruction
	f8_regfile f8_regfile_i (.z(), .*);

	f8_alu #(.data_t(f8_core_pkg::byte_t)) f8_alu8_i (.exec(exec8));
	f8_alu #(.data_t(f8_core_pkg::word_t)) f8_alu16_i (.exec(exec16));

	f8_writeback f8_writeback_i (.*);

endmodule

`default_nettype wire

//--- hw/f8_core_pkg.sv
// f8 core datapath types
// widths, register selection, start address and ALU flag result
`default_nettype none

package f8_core_pkg;

	parameter int ADDR_W = 16;
	parameter int BYTE_W = 8;

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [ADDR_W-1:0] word_t;

	typedef enum logic [1:0]
	{
		REG_X = 2'd0,
		REG_Y = 2'd1,
		REG_Z = 2'd2
	} reg_idx_t;

	// first opcode fetch after reset
	parameter word_t RESET_PC = 16'h4000;

	// packs onto flag byte bits 4:0
	typedef struct packed
	{
		logic o;
		logic z;
		logic n;
		logic c;
		logic h;
	} alu_flags_t;

endpackage

`default_nettype wire

//--- hw/f8_exec_if.sv
// f8 execute channel
// one ALU request and its same-cycle result, for a given operand width
`default_nettype none

interface f8_exec_if #(
	parameter type data_t = f8_core_pkg::byte_t
) ();

	logic valid;
	f8_isa_pkg::alu_op_t op;
	data_t a;
	data_t b;
	logic carry_in;
	data_t result;
	f8_core_pkg::alu_flags_t flags;

	// b arrives already inverted for sub and sbc
	modport issue (output valid, op, a, b, carry_in);

	modport unit (input op, a, b, carry_in, output result, flags);

	// valid marks the single execute cycle
	modport observe (input valid, op, result, flags);

endinterface

`default_nettype wire

//--- hw/f8_isa_pkg.sv
// f8 instruction set for the reduced core
// opcodes, instruction sizes, flag positions and ALU operations
`default_nettype none

package f8_isa_pkg;

	// low three bits of every ALU opcode select the ALU operation
	typedef enum logic [2:0]
	{
		ALU_ADD = 3'd0,
		ALU_ADC = 3'd1,
		ALU_SUB = 3'd2,
		ALU_SBC = 3'd3,
		ALU_OR = 3'd4,
		ALU_AND = 3'd5,
		ALU_XOR = 3'd6,
		ALU_PASS = 3'd7
	} alu_op_t;

	typedef enum logic [7:0]
	{
		OP_NOP = 8'h00,
		OP_TRAP = 8'h01,
		// xl, #imm8
		OP_ADD_XL = 8'h10,
		OP_ADC_XL = 8'h11,
		OP_SUB_XL = 8'h12,
		OP_SBC_XL = 8'h13,
		OP_OR_XL = 8'h14,
		OP_AND_XL = 8'h15,
		OP_XOR_XL = 8'h16,
		OP_LD_XL = 8'h17,
		// y, #imm16
		OP_ADDW_Y = 8'h20,
		OP_ADCW_Y = 8'h21,
		OP_SUBW_Y = 8'h22,
		OP_SBCW_Y = 8'h23,
		OP_ORW_Y = 8'h24,
		OP_XORW_Y = 8'h26,
		OP_LDW_Y = 8'h27,
		// dir16 stores
		OP_LD_DIR_XL = 8'h30,
		OP_LDW_DIR_Y = 8'h31,
		// relative jumps, #d8
		OP_JR = 8'h40,
		OP_JRZ = 8'h41,
		OP_JRNZ = 8'h42,
		OP_JRC = 8'h43,
		OP_JRNC = 8'h44
	} opcode_t;

	typedef enum logic [2:0]
	{
		FLAG_H,
		FLAG_C,
		FLAG_N,
		FLAG_Z,
		FLAG_O
	} flag_e;

	// unknown opcodes run as one byte nops
	function automatic logic [1:0] inst_size(opcode_t op);
		case (op)
			OP_ADD_XL, OP_ADC_XL, OP_SUB_XL, OP_SBC_XL,
			OP_OR_XL, OP_AND_XL, OP_XOR_XL, OP_LD_XL,
			OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC:
				return 2'd2;
			OP_ADDW_Y, OP_ADCW_Y, OP_SUBW_Y, OP_SBCW_Y,
			OP_ORW_Y, OP_XORW_Y, OP_LDW_Y,
			OP_LD_DIR_XL, OP_LDW_DIR_Y:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- hw/f8_regfile.sv
// f8 register file
// x, y, z with byte lane writes, plus the flag byte
`default_nettype none

module f8_regfile (
	input logic clk,
	input logic reset,
	input f8_core_pkg::reg_idx_t write_idx,
	input f8_core_pkg::word_t write_data,
	input logic [1:0] write_en,
	input f8_core_pkg::byte_t flags_next,
	output f8_core_pkg::word_t x,
	output f8_core_pkg::word_t y,
	output f8_core_pkg::word_t z,
	output f8_core_pkg::byte_t flags
);

	f8_core_pkg::word_t regs [3];

	assign x = regs[f8_core_pkg::REG_X];
	assign y = regs[f8_core_pkg::REG_Y];
	assign z = regs[f8_core_pkg::REG_Z];

	// lane 0 is the low byte, lane 1 the high byte
	always_ff @(posedge clk)
	begin
		if (write_en[0])
			regs[write_idx][7:0] <= write_data[7:0];
		if (write_en[1])
			regs[write_idx][15:8] <= write_data[15:8];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= flags_next;
	end

endmodule

`default_nettype wire

//--- hw/f8_sequencer.sv
// f8 sequencer
// byte fetch, instruction assembly, decode, branches and program counter
`default_nettype none

module f8_sequencer #(
	parameter f8_core_pkg::word_t RESET_PC = f8_core_pkg::RESET_PC
) (
	input logic clk,
	input logic reset,
	input f8_core_pkg::byte_t mem_read_data,
	input f8_core_pkg::word_t x,
	input f8_core_pkg::word_t y,
	input f8_core_pkg::byte_t flags,
	output f8_core_pkg::word_t mem_read_addr,
	f8_exec_if.issue exec8,
	f8_exec_if.issue exec16,
	output f8_core_pkg::word_t store_addr,
	output logic store_byte,
	output logic store_word,
	output logic trap
);

	typedef enum logic [1:0]
	{
		ST_START,
		ST_RUN,
		ST_HALT
	} state_t;

	state_t state;
	state_t state_next;
	f8_core_pkg::word_t pc;
	f8_core_pkg::word_t pc_next;
	logic [1:0] cnt;
	logic [1:0] size;
	f8_isa_pkg::opcode_t opcode;
	f8_isa_pkg::opcode_t opcode_q;
	f8_core_pkg::byte_t operand_q;
	f8_core_pkg::word_t imm16;
	f8_isa_pkg::alu_op_t op;
	logic last, execute, taken;
	logic is_alu8, is_alu16, is_st8, is_st16, is_trap;
	logic invert, carry;

	// cnt counts bytes already taken from the current instruction
	assign opcode = (cnt == 2'd0) ? f8_isa_pkg::opcode_t'(mem_read_data) : opcode_q;
	assign size = f8_isa_pkg::inst_size(opcode);
	assign last = (cnt + 2'd1 == size);
	assign execute = (state == ST_RUN) && last;
	assign imm16 = {mem_read_data, operand_q};

	always_comb
	begin
		is_alu8 = 1'b0;
		is_alu16 = 1'b0;
		is_st8 = 1'b0;
		is_st16 = 1'b0;
		is_trap = 1'b0;
		taken = 1'b0;
		unique case (opcode)
			f8_isa_pkg::OP_ADD_XL, f8_isa_pkg::OP_ADC_XL, f8_isa_pkg::OP_SUB_XL,
			f8_isa_pkg::OP_SBC_XL, f8_isa_pkg::OP_OR_XL, f8_isa_pkg::OP_AND_XL,
			f8_isa_pkg::OP_XOR_XL, f8_isa_pkg::OP_LD_XL:
				is_alu8 = 1'b1;
			f8_isa_pkg::OP_ADDW_Y, f8_isa_pkg::OP_ADCW_Y, f8_isa_pkg::OP_SUBW_Y,
			f8_isa_pkg::OP_SBCW_Y, f8_isa_pkg::OP_ORW_Y, f8_isa_pkg::OP_XORW_Y,
			f8_isa_pkg::OP_LDW_Y:
				is_alu16 = 1'b1;
			f8_isa_pkg::OP_LD_DIR_XL: is_st8 = 1'b1;
			f8_isa_pkg::OP_LDW_DIR_Y: is_st16 = 1'b1;
			f8_isa_pkg::OP_JR: taken = 1'b1;
			f8_isa_pkg::OP_JRZ: taken = flags[f8_isa_pkg::FLAG_Z];
			f8_isa_pkg::OP_JRNZ: taken = !flags[f8_isa_pkg::FLAG_Z];
			f8_isa_pkg::OP_JRC: taken = flags[f8_isa_pkg::FLAG_C];
			f8_isa_pkg::OP_JRNC: taken = !flags[f8_isa_pkg::FLAG_C];
			f8_isa_pkg::OP_TRAP: is_trap = 1'b1;
			default: ;
		endcase
	end

	// subtraction is a + ~b + carry
	assign op = f8_isa_pkg::alu_op_t'(opcode[2:0]);
	assign invert = (op == f8_isa_pkg::ALU_SUB) || (op == f8_isa_pkg::ALU_SBC);
	assign carry = (op == f8_isa_pkg::ALU_SUB)
		|| ((op == f8_isa_pkg::ALU_ADC || op == f8_isa_pkg::ALU_SBC)
		&& flags[f8_isa_pkg::FLAG_C]);

	always_comb
	begin
		exec8.valid = execute && is_alu8;
		exec8.op = op;
		exec8.a = x[7:0];
		exec8.b = invert ? ~mem_read_data : mem_read_data;
		exec8.carry_in = carry;
		exec16.valid = execute && is_alu16;
		exec16.op = op;
		exec16.a = y;
		exec16.b = invert ? ~imm16 : imm16;
		exec16.carry_in = carry;
	end

	assign store_addr = imm16;
	assign store_byte = execute && is_st8;
	assign store_word = execute && is_st16;
	assign trap = (state == ST_HALT) || (execute && is_trap);

	// next opcode address leaves in the execute cycle
	always_comb
	begin
		state_next = state;
		pc_next = pc;
		mem_read_addr = pc;
		if (state == ST_START)
			state_next = ST_RUN;
		else if (state == ST_RUN)
		begin
			if (!last)
				mem_read_addr = pc + f8_core_pkg::word_t'(cnt) + 16'd1;
			else if (is_trap)
				state_next = ST_HALT;
			else
			begin
				if (taken)
					pc_next = pc + {{8{mem_read_data[7]}}, mem_read_data};
				else
					pc_next = pc + f8_core_pkg::word_t'(size);
				mem_read_addr = pc_next;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_START;
			pc <= RESET_PC;
			cnt <= 2'd0;
		end
		else
		begin
			state <= state_next;
			pc <= pc_next;
			cnt <= (state == ST_RUN && !last) ? cnt + 2'd1 : 2'd0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (cnt == 2'd0)
			opcode_q <= opcode;
		if (cnt == 2'd1)
			operand_q <= mem_read_data;
	end

endmodule

`default_nettype wire

//--- hw/f8_writeback.sv
// f8 writeback
// merges both ALU results into register, flag and memory writes
`default_nettype none

module f8_writeback (
	f8_exec_if.observe exec8,
	f8_exec_if.observe exec16,
	input f8_core_pkg::byte_t flags,
	input f8_core_pkg::word_t x,
	input f8_core_pkg::word_t y,
	input f8_core_pkg::word_t store_addr,
	input logic store_word,
	input logic store_byte,
	output f8_core_pkg::reg_idx_t write_idx,
	output f8_core_pkg::word_t write_data,
	output logic [1:0] write_en,
	output f8_core_pkg::byte_t flags_next,
	output f8_core_pkg::word_t mem_write_addr,
	output f8_core_pkg::word_t mem_write_data,
	output logic [1:0] mem_write_en
);

	always_comb
	begin
		write_idx = f8_core_pkg::REG_X;
		write_data = {8'h00, exec8.result};
		write_en = 2'b00;
		flags_next = flags;
		if (exec8.valid)
		begin
			write_en = 2'b01;
			// ld xl leaves every flag alone
			if (exec8.op != f8_isa_pkg::ALU_PASS)
			begin
				flags_next[f8_isa_pkg::FLAG_Z] = exec8.flags.z;
				flags_next[f8_isa_pkg::FLAG_N] = exec8.flags.n;
			end
			if (exec8.op inside {f8_isa_pkg::ALU_ADD, f8_isa_pkg::ALU_ADC,
				f8_isa_pkg::ALU_SUB, f8_isa_pkg::ALU_SBC})
			begin
				flags_next[f8_isa_pkg::FLAG_H] = exec8.flags.h;
				flags_next[f8_isa_pkg::FLAG_C] = exec8.flags.c;
				flags_next[f8_isa_pkg::FLAG_O] = exec8.flags.o;
			end
		end
		else if (exec16.valid)
		begin
			write_idx = f8_core_pkg::REG_Y;
			write_data = exec16.result;
			write_en = 2'b11;
			// H is never touched by word ops
			flags_next[f8_isa_pkg::FLAG_Z] = exec16.flags.z;
			flags_next[f8_isa_pkg::FLAG_N] = exec16.flags.n;
			if (exec16.op != f8_isa_pkg::ALU_PASS)
				flags_next[f8_isa_pkg::FLAG_O] = exec16.flags.o;
			if (exec16.op inside {f8_isa_pkg::ALU_ADD, f8_isa_pkg::ALU_ADC,
				f8_isa_pkg::ALU_SUB, f8_isa_pkg::ALU_SBC})
				flags_next[f8_isa_pkg::FLAG_C] = exec16.flags.c;
		end
	end

	// high byte lands at the address plus 1
	assign mem_write_addr = store_addr;
	assign mem_write_data = store_word ? y : {8'h00, x[7:0]};
	assign mem_write_en = {store_word, store_word || store_byte};

endmodule

`default_nettype wire
